/* hw/dma_pkg.sv */
package dma_pkg;

   // Stream word and AXI beat width, 4-byte beats only
   localparam int DATA_W = 32;

   // Writer FSM
   typedef enum logic [1:0] {
      wait_data  = 2'd0,
      start_xfer = 2'd1,
      xfer       = 2'd2,
      wait_bresp = 2'd3
   } wr_state_t;

   // APB register map, byte offsets
   localparam int REG_ADDR   = 'h0;
   localparam int REG_STATUS = 'h4;
   localparam int REG_BURSTS = 'h8;

   localparam int APB_ADDR_W = 4;

endpackage

/* hw/ram_2p.sv */
`timescale 1ns/100ps

module ram_2p #(
   parameter int ADDR_W = 4,
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
      // Read data holds until the next read
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* hw/fifo_sync.sv */
`timescale 1ns/100ps

module fifo_sync #(
   parameter int ADDR_W = 4,
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_i,

   input  logic              w_en_i,
   input  logic [DATA_W-1:0] w_data_i,
   output logic              w_full_o,

   input  logic              r_en_i,
   output logic [DATA_W-1:0] r_data_o,
   output logic              r_empty_o,

   output logic [ADDR_W:0]   level_o,

   // Buffer RAM
   output logic              mem_w_en_o,
   output logic [ADDR_W-1:0] mem_w_addr_o,
   output logic [DATA_W-1:0] mem_w_data_o,
   output logic              mem_r_en_o,
   output logic [ADDR_W-1:0] mem_r_addr_o,
   input  logic [DATA_W-1:0] mem_r_data_i
);

   localparam int DEPTH = 2**ADDR_W;

   logic [ADDR_W-1:0] w_ptr_q;
   logic [ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]   level_q;
   logic              do_write;
   logic              do_read;

   assign w_full_o  = (level_q == (ADDR_W+1)'(DEPTH));
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   // Writes while full and reads while empty are dropped
   assign do_write = w_en_i && !w_full_o;
   assign do_read  = r_en_i && !r_empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (do_write) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (do_read) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   assign mem_w_en_o   = do_write;
   assign mem_w_addr_o = w_ptr_q;
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = do_read;
   assign mem_r_addr_o = r_ptr_q;
   assign r_data_o     = mem_r_data_i;

endmodule

/* hw/axis2axi_in.sv */
`timescale 1ns/100ps

module axis2axi_in import dma_pkg::*; #(
   parameter int AXI_ADDR_W = 16,
   parameter int BURST_W    = 3
) (
   input  logic                  clk_i,
   input  logic                  rst_i,

   // Configuration
   input  logic [AXI_ADDR_W-1:0] cfg_addr_i,
   input  logic                  cfg_valid_i,
   output logic                  cfg_ready_o,

   // Stream input
   input  logic [DATA_W-1:0]     axis_data_i,
   input  logic                  axis_valid_i,
   output logic                  axis_ready_o,

   // AXI write master
   output logic [AXI_ADDR_W-1:0] awaddr_o,
   output logic [7:0]            awlen_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output logic [DATA_W-1:0]     wdata_o,
   output logic                  wvalid_o,
   output logic                  wlast_o,
   input  logic                  wready_i,
   input  logic                  bvalid_i,
   input  logic [1:0]            bresp_i,

   // FIFO buffer RAM
   output logic                  mem_w_en_o,
   output logic [BURST_W:0]      mem_w_addr_o,
   output logic [DATA_W-1:0]     mem_w_data_o,
   output logic                  mem_r_en_o,
   output logic [BURST_W:0]      mem_r_addr_o,
   input  logic [DATA_W-1:0]     mem_r_data_i
);

   localparam int BURST_SIZE = 2**BURST_W;
   localparam int BUFFER_W   = BURST_W + 1;

   wr_state_t             state_q;
   wr_state_t             state_d;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [AXI_ADDR_W-1:0] addr_d;
   logic [BURST_W:0]      awlen_q;
   logic [BURST_W:0]      beat_q;

   logic [DATA_W-1:0]     fifo_data;
   logic                  fifo_empty;
   logic                  fifo_full;
   logic [BUFFER_W:0]     fifo_level;
   logic                  fifo_rd;

   logic                  normal_burst;
   logic                  last_burst;
   logic                  start;
   logic                  beat_done;
   logic                  burst_end;
   logic [BURST_W:0]      raw_len;
   logic [BURST_W:0]      burst_len;

   assign normal_burst = (fifo_level >= (BUFFER_W+1)'(BURST_SIZE));
   assign last_burst   = (fifo_level != '0) && !normal_burst && !axis_valid_i;
   assign start        = (state_q == wait_data) && (normal_burst || last_burst);

   assign beat_done = (state_q == xfer) && wready_i;
   assign burst_end = beat_done && wlast_o;

   always_comb begin
      raw_len = fifo_level[BURST_W:0];
      if (normal_burst) begin
         raw_len = (BURST_W+1)'(BURST_SIZE);
      end
   end

   // A burst may not run past the next 4 KB page
   generate
      if (AXI_ADDR_W >= 13) begin : g_boundary
         logic [12:0] words_left;

         assign words_left = (13'h1000 - {1'b0, addr_q[11:0]}) >> 2;
         assign burst_len  = (13'(raw_len) > words_left) ? words_left[BURST_W:0] : raw_len;
      end else begin : g_no_boundary
         assign burst_len = raw_len;
      end
   endgenerate

   // The read on start prefetches beat 0 into the RAM output register,
   // each accepted beat then fetches the next one
   assign fifo_rd = start || (beat_done && !wlast_o);

   always_comb begin
      state_d = state_q;
      addr_d  = addr_q;
      if (cfg_valid_i) begin
         addr_d = cfg_addr_i;
      end
      case (state_q)
         wait_data: begin
            if (start) begin
               state_d = start_xfer;
            end
         end
         start_xfer: begin
            if (awready_i) begin
               state_d = xfer;
            end
         end
         xfer: begin
            if (burst_end) begin
               addr_d  = addr_q + AXI_ADDR_W'((int'(awlen_q) + 1) * 4);
               state_d = wait_bresp;
            end
         end
         wait_bresp: begin
            // Response code is not checked
            if (bvalid_i) begin
               state_d = wait_data;
            end
         end
         default: state_d = wait_data;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= wait_data;
         addr_q  <= '0;
         awlen_q <= '0;
         beat_q  <= '0;
      end else begin
         state_q <= state_d;
         addr_q  <= addr_d;
         if (start) begin
            awlen_q <= burst_len - 1'b1;
         end
         if (state_q == wait_data) begin
            beat_q <= '0;
         end else if (beat_done) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   assign awaddr_o  = addr_q;
   assign awlen_o   = 8'(awlen_q);
   assign awvalid_o = (state_q == start_xfer);
   // Burst length never exceeds the FIFO level, so data is always there
   assign wvalid_o  = (state_q == xfer);
   assign wlast_o   = (state_q == xfer) && (beat_q == awlen_q);
   assign wdata_o   = fifo_data;

   assign axis_ready_o = !fifo_full;
   assign cfg_ready_o  = fifo_empty && (state_q == wait_data);

   fifo_sync #(
      .ADDR_W(BUFFER_W),
      .DATA_W(DATA_W)
   ) fifo_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .w_en_i      (axis_valid_i),
      .w_data_i    (axis_data_i),
      .w_full_o    (fifo_full),
      .r_en_i      (fifo_rd),
      .r_data_o    (fifo_data),
      .r_empty_o   (fifo_empty),
      .level_o     (fifo_level),
      .mem_w_en_o  (mem_w_en_o),
      .mem_w_addr_o(mem_w_addr_o),
      .mem_w_data_o(mem_w_data_o),
      .mem_r_en_o  (mem_r_en_o),
      .mem_r_addr_o(mem_r_addr_o),
      .mem_r_data_i(mem_r_data_i)
   );

endmodule

/* hw/dma_apb_regs.sv */
`timescale 1ns/100ps

module dma_apb_regs import dma_pkg::*; #(
   parameter int AXI_ADDR_W = 16
) (
   input  logic                  clk_i,
   input  logic                  rst_i,

   // APB slave
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [31:0]           pwdata_i,
   output logic [31:0]           prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,

   // Writer configuration
   output logic [AXI_ADDR_W-1:0] cfg_addr_o,
   output logic                  cfg_valid_o,
   input  logic                  cfg_ready_i,
   input  logic                  bvalid_i
);

   logic [AXI_ADDR_W-1:0] addr_q;
   logic                  cfg_valid_q;
   logic [31:0]           bursts_q;
   logic                  addr_wr;
   logic                  rd_setup;

   assign addr_wr  = psel_i && penable_i && pwrite_i && (paddr_i == APB_ADDR_W'(REG_ADDR));
   // Read data is captured in the setup phase, ready for the access phase
   assign rd_setup = psel_i && !penable_i && !pwrite_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         addr_q      <= '0;
         cfg_valid_q <= 1'b0;
         bursts_q    <= '0;
         prdata_o    <= '0;
      end else begin
         if (addr_wr) begin
            addr_q      <= pwdata_i[AXI_ADDR_W-1:0];
            cfg_valid_q <= 1'b1;
            bursts_q    <= '0;
         end else begin
            if (cfg_valid_q && cfg_ready_i) begin
               cfg_valid_q <= 1'b0;
            end
            if (bvalid_i) begin
               bursts_q <= bursts_q + 1'b1;
            end
         end
         if (rd_setup) begin
            case (paddr_i)
               APB_ADDR_W'(REG_ADDR):   prdata_o <= 32'(addr_q);
               APB_ADDR_W'(REG_STATUS): prdata_o <= {30'd0, cfg_valid_q, cfg_ready_i};
               APB_ADDR_W'(REG_BURSTS): prdata_o <= bursts_q;
               default:                 prdata_o <= '0;
            endcase
         end
      end
   end

   // No wait states, no error responses
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   assign cfg_addr_o  = addr_q;
   assign cfg_valid_o = cfg_valid_q;

endmodule

/* hw/axis_dma_top.sv */
`timescale 1ns/100ps

module axis_dma_top import dma_pkg::*; #(
   parameter int AXI_ADDR_W = 16,
   parameter int BURST_W    = 3
) (
   input  logic                  clk_i,
   input  logic                  rst_i,

   // APB slave
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [31:0]           pwdata_i,
   output logic [31:0]           prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,

   // Stream input
   input  logic [DATA_W-1:0]     axis_data_i,
   input  logic                  axis_valid_i,
   output logic                  axis_ready_o,

   // AXI write master
   output logic [AXI_ADDR_W-1:0] awaddr_o,
   output logic [7:0]            awlen_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output logic [DATA_W-1:0]     wdata_o,
   output logic                  wvalid_o,
   output logic                  wlast_o,
   input  logic                  wready_i,
   input  logic                  bvalid_i,
   input  logic [1:0]            bresp_i
);

   localparam int BUFFER_W = BURST_W + 1;

   logic [AXI_ADDR_W-1:0] cfg_addr;
   logic                  cfg_valid;
   logic                  cfg_ready;

   logic                  mem_w_en;
   logic [BUFFER_W-1:0]   mem_w_addr;
   logic [DATA_W-1:0]     mem_w_data;
   logic                  mem_r_en;
   logic [BUFFER_W-1:0]   mem_r_addr;
   logic [DATA_W-1:0]     mem_r_data;

   dma_apb_regs #(
      .AXI_ADDR_W(AXI_ADDR_W)
   ) dma_apb_regs_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .paddr_i    (paddr_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .cfg_addr_o (cfg_addr),
      .cfg_valid_o(cfg_valid),
      .cfg_ready_i(cfg_ready),
      .bvalid_i   (bvalid_i)
   );

   axis2axi_in #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BURST_W   (BURST_W)
   ) axis2axi_in_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_addr_i  (cfg_addr),
      .cfg_valid_i (cfg_valid),
      .cfg_ready_o (cfg_ready),
      .axis_data_i (axis_data_i),
      .axis_valid_i(axis_valid_i),
      .axis_ready_o(axis_ready_o),
      .awaddr_o    (awaddr_o),
      .awlen_o     (awlen_o),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .wdata_o     (wdata_o),
      .wvalid_o    (wvalid_o),
      .wlast_o     (wlast_o),
      .wready_i    (wready_i),
      .bvalid_i    (bvalid_i),
      .bresp_i     (bresp_i),
      .mem_w_en_o  (mem_w_en),
      .mem_w_addr_o(mem_w_addr),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_addr_o(mem_r_addr),
      .mem_r_data_i(mem_r_data)
   );

   // FIFO storage
   ram_2p #(
      .ADDR_W(BUFFER_W),
      .DATA_W(DATA_W)
   ) ram_2p_inst (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/100ps

module axi_mem_model #(
   parameter int ADDR_W    = 16,
   parameter int LOG_DEPTH = 64
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              stall_en_i,
   input  logic [ADDR_W-1:0] awaddr_i,
   input  logic [7:0]        awlen_i,
   input  logic              awvalid_i,
   output logic              awready_o,
   input  logic [31:0]       wdata_i,
   input  logic              wvalid_i,
   input  logic              wlast_i,
   output logic              wready_o,
   output logic              bvalid_o,
   output logic [1:0]        bresp_o
);

   logic [31:0]       mem [2**(ADDR_W-2)];
   // One entry per accepted write address
   logic [ADDR_W-1:0] log_addr [LOG_DEPTH];
   logic [7:0]        log_len [LOG_DEPTH];
   int                log_count = 0;
   int                wlast_errors = 0;

   integer            seed = 32'h9ffc;
   logic [31:0]       rnd;
   logic              busy_q = 1'b0;
   logic              go_aw_q = 1'b0;
   logic              go_w_q = 1'b0;
   logic              bvalid_q = 1'b0;
   logic [ADDR_W-3:0] word_q = '0;
   logic [7:0]        beat_q = '0;
   logic [7:0]        len_q = '0;

   // One address in flight, data only after its address
   assign awready_o = !busy_q && go_aw_q;
   assign wready_o  = busy_q && go_w_q;
   assign bvalid_o  = bvalid_q;
   assign bresp_o   = 2'b00;

   always @(posedge clk_i) begin
      rnd = $random(seed);
      go_aw_q  <= !stall_en_i || rnd[0];
      go_w_q   <= !stall_en_i || rnd[1];
      bvalid_q <= 1'b0;
      if (rst_i) begin
         busy_q    <= 1'b0;
         log_count <= 0;
      end else if (awvalid_i && awready_o) begin
         busy_q <= 1'b1;
         word_q <= awaddr_i[ADDR_W-1:2];
         beat_q <= '0;
         len_q  <= awlen_i;
         if (log_count < LOG_DEPTH) begin
            log_addr[log_count] <= awaddr_i;
            log_len[log_count]  <= awlen_i;
         end
         log_count <= log_count + 1;
      end else if (wvalid_i && wready_o) begin
         mem[word_q] <= wdata_i;
         word_q      <= word_q + 1'b1;
         beat_q      <= beat_q + 1'b1;
         if (wlast_i != (beat_q == len_q)) begin
            wlast_errors <= wlast_errors + 1;
         end
         if (wlast_i) begin
            busy_q   <= 1'b0;
            bvalid_q <= 1'b1;
         end
      end
   end

endmodule

/* tests/axis_dma_tb.sv */
`timescale 1ns/100ps

module axis_dma_tb import dma_pkg::*; ();

   localparam int AXI_ADDR_W = 16;
   localparam int BURST_W    = 3;
   localparam int BURST_SIZE = 2**BURST_W;
   localparam int NUM_TESTS  = 4;

   // Test table: start address, word count, random stalls on the AXI side
   localparam logic [15:0] T_ADDR [NUM_TESTS] = '{16'h0100, 16'h0200, 16'h0FF0, 16'h3FD0};
   localparam int          T_WORDS [NUM_TESTS] = '{16, 3, 8, 40};
   localparam bit          T_STALL [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

   logic                  clk = 1'b0;
   logic                  rst = 1'b1;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pready;
   logic                  pslverr;
   logic [31:0]           axis_data;
   logic                  axis_valid;
   logic                  axis_ready;
   logic [15:0]           awaddr;
   logic [7:0]            awlen;
   logic                  awvalid;
   logic                  awready;
   logic [31:0]           wdata;
   logic                  wvalid;
   logic                  wlast;
   logic                  wready;
   logic                  bvalid;
   logic [1:0]            bresp;
   logic                  stall_en;
   logic                  saw_full;
   int                    errors;
   int                    passed;
   int                    exp_addr [64];
   int                    exp_len [64];

   always #2 clk = ~clk;

   axis_dma_top #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BURST_W   (BURST_W)
   ) axis_dma_top_inst (
      .clk_i       (clk),
      .rst_i       (rst),
      .paddr_i     (paddr),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .pslverr_o   (pslverr),
      .axis_data_i (axis_data),
      .axis_valid_i(axis_valid),
      .axis_ready_o(axis_ready),
      .awaddr_o    (awaddr),
      .awlen_o     (awlen),
      .awvalid_o   (awvalid),
      .awready_i   (awready),
      .wdata_o     (wdata),
      .wvalid_o    (wvalid),
      .wlast_o     (wlast),
      .wready_i    (wready),
      .bvalid_i    (bvalid),
      .bresp_i     (bresp)
   );

   axi_mem_model #(
      .ADDR_W(AXI_ADDR_W)
   ) mem_model_inst (
      .clk_i     (clk),
      .rst_i     (rst),
      .stall_en_i(stall_en),
      .awaddr_i  (awaddr),
      .awlen_i   (awlen),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wvalid_i  (wvalid),
      .wlast_i   (wlast),
      .wready_o  (wready),
      .bvalid_o  (bvalid),
      .bresp_o   (bresp)
   );

   function automatic logic [31:0] word_value(input logic [15:0] start, input int idx);
      return {start, 16'(idx)};
   endfunction

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic apb_write(input int addr, input logic [31:0] data);
      @(posedge clk);
      paddr   <= APB_ADDR_W'(addr);
      pwdata  <= data;
      pwrite  <= 1'b1;
      psel    <= 1'b1;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input int addr, output logic [31:0] data);
      @(posedge clk);
      paddr   <= APB_ADDR_W'(addr);
      pwrite  <= 1'b0;
      psel    <= 1'b1;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      // No wait states and no error response in the access phase
      expect_equal("pready", pready, 32'h1);
      expect_equal("pslverr", pslverr, 32'h0);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Valid stays high until every word is taken
   task automatic stream_words(input logic [15:0] start, input int count);
      int   sent;
      logic accepted;
      sent = 0;
      @(posedge clk);
      axis_valid <= 1'b1;
      axis_data  <= word_value(start, 0);
      while (sent < count) begin
         @(negedge clk);
         accepted = axis_ready;
         if (!accepted) begin
            saw_full = 1'b1;
         end
         @(posedge clk);
         if (accepted) begin
            sent++;
            axis_data <= word_value(start, sent);
            if (sent == count) begin
               axis_valid <= 1'b0;
            end
         end
      end
   endtask

   // Watchdog
   initial begin
      int total;
      total = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         total += T_WORDS[i];
      end
      repeat (total * 40 + 2000) @(posedge clk);
      $display("Timeout: the DMA did not finish within %0d cycles", total * 40 + 2000);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [31:0] rdata;
      int          addr;
      int          left;
      int          len;
      int          nexp;
      int          base;
      int          start_err;
      int          wlast_base;
      int          got_addr;
      int          got_len;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      axis_data  = '0;
      axis_valid = 1'b0;
      stall_en   = 1'b0;
      saw_full   = 1'b0;
      errors     = 0;
      passed     = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Register access after reset
      start_err = errors;
      @(negedge clk);
      expect_equal("awvalid", awvalid, 32'h0);
      expect_equal("wvalid", wvalid, 32'h0);
      expect_equal("wlast", wlast, 32'h0);
      expect_equal("axis_ready", axis_ready, 32'h1);
      apb_read(REG_STATUS, rdata);
      expect_equal("REG_STATUS", rdata, 32'h1);
      apb_read(REG_BURSTS, rdata);
      expect_equal("REG_BURSTS", rdata, 32'h0);
      apb_write(REG_ADDR, 32'h0000_1234);
      apb_read(REG_ADDR, rdata);
      expect_equal("REG_ADDR", rdata, 32'h0000_1234);
      passed += (errors == start_err) ? 1 : 0;
      $display("test 1: register access, %s", (errors == start_err) ? "passed" : "failed");

      for (int t = 0; t < NUM_TESTS; t++) begin
         start_err  = errors;
         stall_en  <= T_STALL[t];
         saw_full   = 1'b0;
         apb_write(REG_ADDR, 32'(T_ADDR[t]));
         base       = mem_model_inst.log_count;
         wlast_base = mem_model_inst.wlast_errors;
         stream_words(T_ADDR[t], T_WORDS[t]);
         rdata = '0;
         while (rdata != 32'h1) begin
            apb_read(REG_STATUS, rdata);
         end

         // Greedy split into bursts of up to 8 words, cut at 4 KB pages
         addr = int'(T_ADDR[t]);
         left = T_WORDS[t];
         nexp = 0;
         while (left > 0) begin
            len = (left < BURST_SIZE) ? left : BURST_SIZE;
            if ((4096 - addr % 4096) / 4 < len) begin
               len = (4096 - addr % 4096) / 4;
            end
            exp_addr[nexp] = addr;
            exp_len[nexp]  = len - 1;
            nexp++;
            addr += 4 * len;
            left -= len;
         end

         if (mem_model_inst.log_count - base != nexp) begin
            $display("** Error at %0d ns: burst count = %0d, expected %0d", $time,
                     mem_model_inst.log_count - base, nexp);
            errors++;
         end else begin
            for (int i = 0; i < nexp; i++) begin
               got_addr = int'(mem_model_inst.log_addr[base + i]);
               got_len  = int'(mem_model_inst.log_len[base + i]);
               expect_equal($sformatf("awaddr of burst %0d", i), got_addr, exp_addr[i]);
               expect_equal($sformatf("awlen of burst %0d", i), got_len, exp_len[i]);
               if (got_addr % 4096 + 4 * (got_len + 1) > 4096) begin
                  $display("Burst %0d at 0x%04h crosses a 4 KB boundary", i, got_addr);
                  errors++;
               end
            end
         end
         for (int i = 0; i < T_WORDS[t]; i++) begin
            expect_equal($sformatf("memory word at 0x%04h", int'(T_ADDR[t]) + 4 * i),
                         mem_model_inst.mem[(int'(T_ADDR[t]) >> 2) + i],
                         word_value(T_ADDR[t], i));
         end
         apb_read(REG_BURSTS, rdata);
         expect_equal("REG_BURSTS", rdata, nexp);
         if (mem_model_inst.wlast_errors != wlast_base) begin
            $display("wlast did not mark the final beat of a burst");
            errors++;
         end
         if (T_STALL[t] && !saw_full) begin
            $display("axis_ready never dropped although the FIFO should have filled");
            errors++;
         end
         passed += (errors == start_err) ? 1 : 0;
         $display("test %0d: %0d words at 0x%04h, %0d bursts, %s", t + 2, T_WORDS[t],
                  T_ADDR[t], nexp, (errors == start_err) ? "passed" : "failed");
      end

      $display("%0d of %0d tests passed, %0d errors", passed, NUM_TESTS + 1, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
hw/dma_pkg.sv
hw/ram_2p.sv
hw/fifo_sync.sv
hw/axis2axi_in.sv
hw/dma_apb_regs.sv
hw/axis_dma_top.sv
tests/axi_mem_model.sv
tests/axis_dma_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module axis_dma_tb -f build.f &&
   ./obj_dir/Vaxis_dma_tb | tee /dev/stderr | grep -q "TEST OK" &&
   echo "Simulation passed" ||
   { echo "Simulation failed"; exit 1; }
